// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dual_issue_tb
FILELIST  = dual_issue_top.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== dual_issue_top.f ====
+incdir+src
src/fetch_pkg.sv
src/pipe_pkg.sv
src/issue_ctrl.sv
src/pipe_track.sv
src/operand_bypass.sv
src/issue_regfile.sv
src/dual_issue_top.sv
verification/dual_issue_tb.sv

// ==== src/dual_issue_top.sv ====
// Dual-issue stage top level
// Connects issue control, the two pipe trackers, register file and bypass

`timescale 1ns/1ps

module dual_issue_top
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  fetch_pkg::fetch_word_t fetch0_i,
    input  fetch_pkg::fetch_word_t fetch1_i,
    input  logic                   redirect_i,
    input  fetch_pkg::pc_t         redirect_target_i,
    input  logic                   lsu_stall_i,
    input  fetch_pkg::word_t       alu0_result_i,
    input  fetch_pkg::word_t       alu1_result_i,
    input  fetch_pkg::word_t       mem_result_i,
    output logic                   fetch0_accept_o,
    output logic                   fetch1_accept_o,
    output logic                   branch_request_o,
    output fetch_pkg::pc_t         branch_pc_o,
    output logic                   exec0_valid_o,
    output logic                   exec1_valid_o,
    output fetch_pkg::issue_slot_t slot0_o,
    output fetch_pkg::issue_slot_t slot1_o
);

    fetch_pkg::word_t       slot_a_instr_w, slot_b_instr_w;
    fetch_pkg::pc_t         slot_a_pc_w, slot_b_pc_w;
    pipe_pkg::issue_req_t   slot_a_req_w, slot_b_req_w;
    fetch_pkg::reg_idx_t    a_ra_w, a_rb_w, b_ra_w, b_rb_w;
    pipe_pkg::stage_t       p0_e1_w, p0_wb_w, p1_e1_w, p1_wb_w;
    fetch_pkg::word_t       ra0_val_w, rb0_val_w, ra1_val_w, rb1_val_w;
    fetch_pkg::word_t [1:0] bypass0_w, bypass1_w;

    issue_ctrl u_issue_ctrl (
        .clk_i, .rst_i, .fetch0_i, .fetch1_i, .redirect_i, .redirect_target_i,
        .lsu_stall_i, .pipe0_e1_i(p0_e1_w), .pipe1_e1_i(p1_e1_w),
        .fetch0_accept_o, .fetch1_accept_o, .branch_request_o, .branch_pc_o,
        .slot_a_instr_o(slot_a_instr_w), .slot_a_pc_o(slot_a_pc_w),
        .slot_b_instr_o(slot_b_instr_w), .slot_b_pc_o(slot_b_pc_w),
        .slot_a_req_o(slot_a_req_w), .slot_b_req_o(slot_b_req_w),
        .slot_a_ra_o(a_ra_w), .slot_a_rb_o(a_rb_w),
        .slot_b_ra_o(b_ra_w), .slot_b_rb_o(b_rb_w));

    pipe_track u_pipe0 (.clk_i, .rst_i, .issue_i(slot_a_req_w), .alu_result_i(alu0_result_i),
        .mem_result_i, .e1_o(p0_e1_w), .wb_o(p0_wb_w));
    pipe_track u_pipe1 (.clk_i, .rst_i, .issue_i(slot_b_req_w), .alu_result_i(alu1_result_i),
        .mem_result_i, .e1_o(p1_e1_w), .wb_o(p1_wb_w));

    issue_regfile u_regfile (.clk_i, .rst_i, .wb0_i(p0_wb_w), .wb1_i(p1_wb_w),
        .ra0_i(a_ra_w), .rb0_i(a_rb_w), .ra1_i(b_ra_w), .rb1_i(b_rb_w),
        .ra0_value_o(ra0_val_w), .rb0_value_o(rb0_val_w),
        .ra1_value_o(ra1_val_w), .rb1_value_o(rb1_val_w));

    operand_bypass u_bypass0 (.ra_i(a_ra_w), .rb_i(a_rb_w),
        .ra_file_i(ra0_val_w), .rb_file_i(rb0_val_w),
        .pipe0_e1_i(p0_e1_w), .pipe1_e1_i(p1_e1_w), .pipe0_wb_i(p0_wb_w),
        .pipe1_wb_i(p1_wb_w), .operands_o(bypass0_w));
    operand_bypass u_bypass1 (.ra_i(b_ra_w), .rb_i(b_rb_w),
        .ra_file_i(ra1_val_w), .rb_file_i(rb1_val_w),
        .pipe0_e1_i(p0_e1_w), .pipe1_e1_i(p1_e1_w), .pipe0_wb_i(p0_wb_w),
        .pipe1_wb_i(p1_wb_w), .operands_o(bypass1_w));

    // Issue strobes and slot payloads out to the execute units
    assign exec0_valid_o = slot_a_req_w.valid;
    assign exec1_valid_o = slot_b_req_w.valid;
    assign slot0_o       = {slot_a_instr_w, slot_a_pc_w, bypass0_w};
    assign slot1_o       = {slot_b_instr_w, slot_b_pc_w, bypass1_w};

endmodule

// ==== src/fetch_pkg.sv ====
// Fetch side types
// Words, addresses and register indices, plus the fetched and issued forms

`include "issue_defines.svh"

package fetch_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`XLEN-1:0]      pc_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // One word from the fetch unit with its predecode bits
    typedef struct packed {
        logic  valid;
        word_t instr;
        pc_t   pc;
        logic  is_exec;
        logic  is_load;
        logic  is_branch;
        logic  rd_valid;
    } fetch_word_t;

    // What an execution pipe receives for an issued instruction
    typedef struct packed {
        word_t opcode;
        pc_t   pc;
        word_t ra_operand;
        word_t rb_operand;
    } issue_slot_t;

endpackage

// ==== src/issue_ctrl.sv ====
// Issue control for the dual-issue pipeline
// Tracks the expected PC, picks slots A and B from the fetched words,
// applies the pairing rules and the load-use scoreboard

`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_ctrl
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  fetch_pkg::fetch_word_t fetch0_i,
    input  fetch_pkg::fetch_word_t fetch1_i,
    input  logic                   redirect_i,
    input  fetch_pkg::pc_t         redirect_target_i,
    input  logic                   lsu_stall_i,
    input  pipe_pkg::stage_t       pipe0_e1_i,
    input  pipe_pkg::stage_t       pipe1_e1_i,
    output logic                   fetch0_accept_o,
    output logic                   fetch1_accept_o,
    output logic                   branch_request_o,
    output fetch_pkg::pc_t         branch_pc_o,
    output fetch_pkg::word_t       slot_a_instr_o,
    output fetch_pkg::pc_t         slot_a_pc_o,
    output fetch_pkg::word_t       slot_b_instr_o,
    output fetch_pkg::pc_t         slot_b_pc_o,
    output pipe_pkg::issue_req_t   slot_a_req_o,
    output pipe_pkg::issue_req_t   slot_b_req_o,
    output fetch_pkg::reg_idx_t    slot_a_ra_o,
    output fetch_pkg::reg_idx_t    slot_a_rb_o,
    output fetch_pkg::reg_idx_t    slot_b_ra_o,
    output fetch_pkg::reg_idx_t    slot_b_rb_o
);

    fetch_pkg::pc_t         pc_q;
    fetch_pkg::fetch_word_t slot_a;
    fetch_pkg::reg_idx_t    a_rd;
    fetch_pkg::reg_idx_t    b_rd;
    logic [`NUM_REGS-1:0]   sb_a;
    logic [`NUM_REGS-1:0]   sb_b;
    logic                   sel0;
    logic                   sel1;
    logic                   block;
    logic                   pair_ok;
    logic                   issue_a;
    logic                   issue_b;

    // ----------------------------------------
    // Slot selection against the expected PC
    // ----------------------------------------
    assign sel0   = fetch0_i.valid && (fetch0_i.pc == pc_q);
    assign sel1   = !sel0 && fetch1_i.valid && (fetch1_i.pc == pc_q);
    assign slot_a = sel0 ? fetch0_i : fetch1_i;
    assign block  = lsu_stall_i || redirect_i;

    assign branch_request_o = !sel0 && !sel1 && (fetch0_i.valid || fetch1_i.valid);
    assign branch_pc_o      = pc_q;

    assign slot_a_ra_o = slot_a.instr[`RS1_LSB +: `REG_IDX_W];
    assign slot_a_rb_o = slot_a.instr[`RS2_LSB +: `REG_IDX_W];
    assign a_rd        = slot_a.instr[`RD_LSB +: `REG_IDX_W];
    assign slot_b_ra_o = fetch1_i.instr[`RS1_LSB +: `REG_IDX_W];
    assign slot_b_rb_o = fetch1_i.instr[`RS2_LSB +: `REG_IDX_W];
    assign b_rd        = fetch1_i.instr[`RD_LSB +: `REG_IDX_W];

    // Slot B can only take an ALU op, branch or load, and one load per cycle
    assign pair_ok = (slot_a.is_exec || slot_a.is_load)
                  && (fetch1_i.is_exec || fetch1_i.is_branch || fetch1_i.is_load)
                  && !(slot_a.is_load && fetch1_i.is_load);

    // ----------------------------------------
    // Load-use scoreboard and issue decision
    // ----------------------------------------
    always_comb
    begin
        sb_a = '0;
        if (pipe0_e1_i.is_load)
            sb_a[pipe0_e1_i.rd] = 1'b1;
        if (pipe1_e1_i.is_load)
            sb_a[pipe1_e1_i.rd] = 1'b1;

        issue_a = !block && (sel0 || sel1)
               && !(sb_a[slot_a_ra_o] || sb_a[slot_a_rb_o] || sb_a[a_rd]);

        // Slot B must also wait on slot A's own result
        sb_b = sb_a;
        if (slot_a.rd_valid && (a_rd != '0))
            sb_b[a_rd] = 1'b1;

        issue_b = issue_a && sel0 && fetch1_i.valid && pair_ok
               && !(sb_b[slot_b_ra_o] || sb_b[slot_b_rb_o] || sb_b[b_rd]);
    end

    // A word skipped over by a fetch1 match is dropped
    assign fetch0_accept_o = (sel0 && issue_a) || (sel1 && !block);
    assign fetch1_accept_o = (sel1 && issue_a) || issue_b;

    assign slot_a_instr_o = slot_a.instr;
    assign slot_a_pc_o    = slot_a.pc;
    assign slot_b_instr_o = fetch1_i.instr;
    assign slot_b_pc_o    = fetch1_i.pc;

    assign slot_a_req_o = '{valid: issue_a, rd_valid: slot_a.rd_valid,
                            is_load: slot_a.is_load, rd: a_rd};
    assign slot_b_req_o = '{valid: issue_b, rd_valid: fetch1_i.rd_valid,
                            is_load: fetch1_i.is_load, rd: b_rd};

    // Expected PC
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            pc_q <= `RESET_PC;
        else if (redirect_i)
            pc_q <= redirect_target_i;
        else if (issue_b)
            pc_q <= pc_q + fetch_pkg::pc_t'(2 * `INSTR_BYTES);
        else if (issue_a)
            pc_q <= pc_q + fetch_pkg::pc_t'(`INSTR_BYTES);
    end

    // Slot B only rides along with slot A, as the word right after it
    a_b_needs_a: assert property (@(posedge clk_i) disable iff (rst_i)
        slot_b_req_o.valid |-> slot_a_req_o.valid
                               && (slot_b_pc_o == slot_a_pc_o + fetch_pkg::pc_t'(`INSTR_BYTES)));

    // A stalled cycle leaves E1 empty and the PC unmoved unless redirected
    a_stall_blocks: assert property (@(posedge clk_i) disable iff (rst_i)
        lsu_stall_i |=> !(pipe0_e1_i.wr || pipe1_e1_i.wr)
                        && (pc_q == ($past(redirect_i) ? $past(redirect_target_i)
                                                       : $past(pc_q))));

endmodule

// ==== src/issue_defines.svh ====
// Issue stage widths and opcode field positions
// Shared by the packages and the issue stage RTL

`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// Datapath and register file sizing
`define XLEN        32
`define REG_IDX_W   5
`define NUM_REGS    32
`define INSTR_BYTES 4

// Register fields inside a 32-bit RISC-V opcode
`define RS1_LSB     15
`define RS2_LSB     20
`define RD_LSB      7

`define RESET_PC    32'h0000_0000

`endif

// ==== src/issue_regfile.sv ====
// Integer register file
// Two write ports from the WB stages, four asynchronous read ports

`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_regfile
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  pipe_pkg::stage_t    wb0_i,
    input  pipe_pkg::stage_t    wb1_i,
    input  fetch_pkg::reg_idx_t ra0_i,
    input  fetch_pkg::reg_idx_t rb0_i,
    input  fetch_pkg::reg_idx_t ra1_i,
    input  fetch_pkg::reg_idx_t rb1_i,
    output fetch_pkg::word_t    ra0_value_o,
    output fetch_pkg::word_t    rb0_value_o,
    output fetch_pkg::word_t    ra1_value_o,
    output fetch_pkg::word_t    rb1_value_o
);

    fetch_pkg::word_t regs_q [`NUM_REGS];

    // Pipe1 is the younger instruction so its write lands last
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs_q[i] <= '0;
        end
        else
        begin
            if (wb0_i.wr && (wb0_i.rd != '0))
                regs_q[wb0_i.rd] <= wb0_i.result;
            if (wb1_i.wr && (wb1_i.rd != '0))
                regs_q[wb1_i.rd] <= wb1_i.result;
        end
    end

    assign ra0_value_o = regs_q[ra0_i];
    assign rb0_value_o = regs_q[rb0_i];
    assign ra1_value_o = regs_q[ra1_i];
    assign rb1_value_o = regs_q[rb1_i];

endmodule

// ==== src/operand_bypass.sv ====
// Operand forwarding for one issue slot
// Picks the newest in-flight value for each source register

`timescale 1ns/1ps

module operand_bypass
(
    input  fetch_pkg::reg_idx_t    ra_i,
    input  fetch_pkg::reg_idx_t    rb_i,
    input  fetch_pkg::word_t       ra_file_i,
    input  fetch_pkg::word_t       rb_file_i,
    input  pipe_pkg::stage_t       pipe0_e1_i,
    input  pipe_pkg::stage_t       pipe1_e1_i,
    input  pipe_pkg::stage_t       pipe0_wb_i,
    input  pipe_pkg::stage_t       pipe1_wb_i,
    output fetch_pkg::word_t [1:0] operands_o
);

    // Later checks are younger writers and win
    function automatic fetch_pkg::word_t pick(fetch_pkg::reg_idx_t idx,
                                              fetch_pkg::word_t file_val);
        fetch_pkg::word_t val;
        val = file_val;
        if (pipe0_wb_i.wr && (pipe0_wb_i.rd == idx))
            val = pipe0_wb_i.result;
        if (pipe1_wb_i.wr && (pipe1_wb_i.rd == idx))
            val = pipe1_wb_i.result;
        if (pipe0_e1_i.wr && (pipe0_e1_i.rd == idx))
            val = pipe0_e1_i.result;
        if (pipe1_e1_i.wr && (pipe1_e1_i.rd == idx))
            val = pipe1_e1_i.result;
        // x0 is hardwired
        if (idx == '0)
            val = '0;
        return val;
    endfunction

    // Index 1 carries ra and index 0 carries rb, matching issue_slot_t
    always_comb
    begin
        operands_o[1] = pick(ra_i, ra_file_i);
        operands_o[0] = pick(rb_i, rb_file_i);
    end

endmodule

// ==== src/pipe_pkg.sv ====
// Pipeline side types
// Stage occupancy for E1 and WB, and the per-slot request into a pipe

package pipe_pkg;

    // Contents of one E1 or WB stage
    typedef struct packed {
        logic               wr;
        logic               is_load;
        fetch_pkg::reg_idx_t rd;
        fetch_pkg::word_t    result;
    } stage_t;

    // Sent by the issue control into one pipe
    typedef struct packed {
        logic               valid;
        logic               rd_valid;
        logic               is_load;
        fetch_pkg::reg_idx_t rd;
    } issue_req_t;

endpackage

// ==== src/pipe_track.sv ====
// Per-pipe stage tracking
// Holds what occupies E1 and WB and captures the ALU or load result

`timescale 1ns/1ps

module pipe_track
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  pipe_pkg::issue_req_t issue_i,
    input  fetch_pkg::word_t     alu_result_i,
    input  fetch_pkg::word_t     mem_result_i,
    output pipe_pkg::stage_t     e1_o,
    output pipe_pkg::stage_t     wb_o
);

    pipe_pkg::issue_req_t e1_req_q;
    logic                 wb_wr_q;
    logic                 wb_load_q;
    fetch_pkg::reg_idx_t  wb_rd_q;
    fetch_pkg::word_t     wb_result_q;

    // E1 result comes straight from this pipe's ALU
    assign e1_o = '{wr: e1_req_q.valid && e1_req_q.rd_valid,
                    is_load: e1_req_q.valid && e1_req_q.is_load,
                    rd: e1_req_q.rd, result: alu_result_i};

    // Loads see their data only during WB
    assign wb_o = '{wr: wb_wr_q, is_load: wb_load_q, rd: wb_rd_q,
                    result: wb_load_q ? mem_result_i : wb_result_q};

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            e1_req_q  <= '0;
            wb_wr_q   <= 1'b0;
            wb_load_q <= 1'b0;
            wb_rd_q   <= '0;
        end
        else
        begin
            e1_req_q  <= issue_i;
            wb_wr_q   <= e1_o.wr;
            wb_load_q <= e1_o.is_load;
            wb_rd_q   <= e1_o.rd;
        end
    end

    always_ff @(posedge clk_i)
        wb_result_q <= e1_o.result;

    a_no_load_waw: assert property (@(posedge clk_i) disable iff (rst_i)
        (e1_o.is_load && issue_i.valid && issue_i.rd_valid) |-> (issue_i.rd != e1_o.rd));

endmodule

// ==== verification/dual_issue_tb.sv ====
// Testbench for the dual-issue stage
// Runs a random program and checks the DUT against a reference model
// of expected PC, pairing, load-use holds and register values

`timescale 1ns/1ps
`include "issue_defines.svh"

module dual_issue_tb;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSTR    = 400;
    // Stalls, redirects and holds cost well under four cycles per instruction
    localparam int MAX_CYCLES   = RESET_CYCLES + 4 * NUM_INSTR;

    logic                   clk_i, rst_i, redirect_i, lsu_stall_i;
    fetch_pkg::fetch_word_t fetch0_i, fetch1_i;
    fetch_pkg::pc_t         redirect_target_i, branch_pc_o;
    fetch_pkg::word_t       alu0_result_i, alu1_result_i, mem_result_i;
    logic                   fetch0_accept_o, fetch1_accept_o, branch_request_o;
    logic                   exec0_valid_o, exec1_valid_o;
    fetch_pkg::issue_slot_t slot0_o, slot1_o;

    // Program image
    // Kind 0 and 1 are ALU ops, 2 is a load, 3 is a branch
    fetch_pkg::word_t prog_instr [64];
    logic [1:0]       prog_kind  [64];

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------
    fetch_pkg::pc_t         model_pc, fpc;
    fetch_pkg::word_t       reg_model [`NUM_REGS];
    logic                   e1_load_v;
    fetch_pkg::reg_idx_t    e1_load_rd;
    logic [`NUM_REGS-1:0]   load_busy, busy_b;
    fetch_pkg::fetch_word_t slot_a;
    logic                   match0, match1, unblocked;
    logic                   exp_a, exp_b, exp_br, exp_acc0, exp_acc1;
    logic [4:0]             strobes, exp_strobes;
    logic [63:0]            ops0, ops1, exp_ops0, exp_ops1;
    fetch_pkg::word_t       exp_op0, exp_op1;
    logic [31:0]            lfsr_q;
    int                     issued;
    int                     cycle_count = 0;

    dual_issue_top dual_issue_top_inst (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic fetch_pkg::reg_idx_t field_at(fetch_pkg::word_t instr, int lsb);
        return instr[lsb +: `REG_IDX_W];
    endfunction

    // True when rs1, rs2 or rd is in the busy set
    function automatic logic touches(logic [`NUM_REGS-1:0] busy, fetch_pkg::word_t instr);
        return busy[field_at(instr, `RS1_LSB)] || busy[field_at(instr, `RS2_LSB)]
            || busy[field_at(instr, `RD_LSB)];
    endfunction

    function automatic fetch_pkg::fetch_word_t word_at(fetch_pkg::pc_t pc);
        logic [1:0] kind;
        kind = prog_kind[pc[7:2]];
        return '{valid: 1'b1, instr: prog_instr[pc[7:2]], pc: pc, is_exec: !kind[1],
                 is_load: kind == 2'd2, is_branch: kind == 2'd3, rd_valid: kind != 2'd3};
    endfunction

    // Galois LFSR, stepped once per bit
    task automatic draw(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value  = {value[30:0], lfsr_q[0]};
            lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
        end
    endtask

    task automatic halt_run();
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] want);
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want);
        halt_run();
    endtask

    // Expected issue decision for the current cycle
    assign load_busy = e1_load_v ? (`NUM_REGS'(1) << e1_load_rd) : '0;

    always_comb
    begin
        match0    = fetch0_i.valid && (fetch0_i.pc == model_pc);
        match1    = !match0 && fetch1_i.valid && (fetch1_i.pc == model_pc);
        slot_a    = match0 ? fetch0_i : fetch1_i;
        unblocked = !lsu_stall_i && !redirect_i;
        busy_b    = load_busy;
        if (slot_a.rd_valid && (field_at(slot_a.instr, `RD_LSB) != '0))
            busy_b[field_at(slot_a.instr, `RD_LSB)] = 1'b1;
        exp_br = !match0 && !match1 && (fetch0_i.valid || fetch1_i.valid);
        exp_a  = unblocked && (match0 || match1) && !touches(load_busy, slot_a.instr);
        exp_b  = exp_a && match0 && fetch1_i.valid
              && (slot_a.is_exec || slot_a.is_load)
              && (fetch1_i.is_exec || fetch1_i.is_branch || fetch1_i.is_load)
              && !(slot_a.is_load && fetch1_i.is_load)
              && !touches(busy_b, fetch1_i.instr);
        exp_acc0 = (match0 && exp_a) || (match1 && unblocked);
        exp_acc1 = (match1 && exp_a) || exp_b;
    end

    assign strobes     = {fetch0_accept_o, fetch1_accept_o, exec0_valid_o, exec1_valid_o,
                          branch_request_o};
    assign exp_strobes = {exp_acc0, exp_acc1, exp_a, exp_b, exp_br};
    assign ops0        = {slot0_o.ra_operand, slot0_o.rb_operand};
    assign ops1        = {slot1_o.ra_operand, slot1_o.rb_operand};
    assign exp_ops0    = {reg_model[field_at(slot_a.instr, `RS1_LSB)],
                          reg_model[field_at(slot_a.instr, `RS2_LSB)]};
    assign exp_ops1    = {reg_model[field_at(fetch1_i.instr, `RS1_LSB)],
                          reg_model[field_at(fetch1_i.instr, `RS2_LSB)]};
    // Opcodes in program order starting at the expected PC
    assign exp_op0     = prog_instr[model_pc[7:2]];
    assign exp_op1     = prog_instr[6'(model_pc[7:2] + 6'd1)];

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_strobes: assert property (@(posedge clk_i) disable iff (rst_i) strobes == exp_strobes)
        else mismatch({"{fetch0_accept_o,fetch1_accept_o,exec0_valid_o,exec1_valid_o,",
                       "branch_request_o}"},
                      64'($sampled(strobes)), 64'($sampled(exp_strobes)));
    a_branch_pc: assert property (@(posedge clk_i) disable iff (rst_i)
        branch_request_o |-> branch_pc_o == model_pc)
        else mismatch("branch_pc_o", 64'($sampled(branch_pc_o)), 64'($sampled(model_pc)));
    a_pc0: assert property (@(posedge clk_i) disable iff (rst_i)
        exec0_valid_o |-> slot0_o.pc == model_pc)
        else mismatch("slot0_o.pc", 64'($sampled(slot0_o.pc)), 64'($sampled(model_pc)));
    a_pc1: assert property (@(posedge clk_i) disable iff (rst_i)
        exec1_valid_o |-> slot1_o.pc == model_pc + 32'd4)
        else mismatch("slot1_o.pc", 64'($sampled(slot1_o.pc)),
                      64'($sampled(model_pc + 32'd4)));
    a_op0: assert property (@(posedge clk_i) disable iff (rst_i)
        exec0_valid_o |-> slot0_o.opcode == exp_op0)
        else mismatch("slot0_o.opcode", 64'($sampled(slot0_o.opcode)),
                      64'($sampled(exp_op0)));
    a_op1: assert property (@(posedge clk_i) disable iff (rst_i)
        exec1_valid_o |-> slot1_o.opcode == exp_op1)
        else mismatch("slot1_o.opcode", 64'($sampled(slot1_o.opcode)),
                      64'($sampled(exp_op1)));
    a_ops0: assert property (@(posedge clk_i) disable iff (rst_i)
        exec0_valid_o |-> ops0 == exp_ops0)
        else mismatch("slot0_o operands", $sampled(ops0), $sampled(exp_ops0));
    a_ops1: assert property (@(posedge clk_i) disable iff (rst_i)
        exec1_valid_o |-> ops1 == exp_ops1)
        else mismatch("slot1_o operands", $sampled(ops1), $sampled(exp_ops1));

    // Advance the model by one cycle and drive the next cycle's inputs
    task automatic step_cycle();
        logic [31:0] v0, v1, vm, r;
        fetch_pkg::pc_t next_fpc;
        draw(32, v0);
        draw(32, v1);
        draw(32, vm);
        alu0_result_i <= v0;
        alu1_result_i <= v1;
        mem_result_i  <= vm;
        // Older load in WB commits before the pair now entering E1
        if (e1_load_v && (e1_load_rd != '0))
            reg_model[e1_load_rd] <= vm;
        if (exp_a && slot_a.rd_valid && !slot_a.is_load
            && (field_at(slot_a.instr, `RD_LSB) != '0))
            reg_model[field_at(slot_a.instr, `RD_LSB)] <= v0;
        if (exp_b && fetch1_i.rd_valid && !fetch1_i.is_load
            && (field_at(fetch1_i.instr, `RD_LSB) != '0))
            reg_model[field_at(fetch1_i.instr, `RD_LSB)] <= v1;
        e1_load_v  <= (exp_a && slot_a.is_load) || (exp_b && fetch1_i.is_load);
        e1_load_rd <= (exp_a && slot_a.is_load) ? field_at(slot_a.instr, `RD_LSB)
                                                : field_at(fetch1_i.instr, `RD_LSB);
        if (redirect_i)
            model_pc <= redirect_target_i;
        else if (exp_b)
            model_pc <= model_pc + 32'd8;
        else if (exp_a)
            model_pc <= model_pc + 32'd4;
        issued += int'(exp_a) + int'(exp_b);

        // Fetch unit follows accepts, redirects and mispredicts
        next_fpc = fpc + (exp_acc0 ? 32'd4 : 32'd0) + (exp_acc1 ? 32'd4 : 32'd0);
        draw(4, r);
        if (redirect_i)
            next_fpc = redirect_target_i;
        else if (exp_br)
            next_fpc = model_pc;
        else if (r[3:0] == 4'd0)
            next_fpc = next_fpc - 32'd4;
        else if (r[3:0] == 4'd1)
            next_fpc = next_fpc + 32'd8;
        fpc      <= next_fpc;
        fetch0_i <= word_at(next_fpc);
        fetch1_i <= word_at(next_fpc + 32'd4);

        draw(4, r);
        redirect_i <= (r[3:0] == 4'd0);
        draw(6, r);
        redirect_target_i <= {24'd0, r[5:0], 2'b00};
        draw(3, r);
        lsu_stall_i <= (r[2:0] == 3'd0);
    endtask

    always @(posedge clk_i)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d instructions issued",
                     cycle_count, issued);
            halt_run();
        end
    end

    initial
    begin
        logic [31:0] bits, ra, rb, rd, kind;
        rst_i             = 1'b1;
        redirect_i        = 1'b0;
        lsu_stall_i       = 1'b0;
        fetch0_i          = '0;
        fetch1_i          = '0;
        redirect_target_i = '0;
        alu0_result_i     = '0;
        alu1_result_i     = '0;
        mem_result_i      = '0;
        lfsr_q            = 32'hcfec3e58;
        model_pc          = `RESET_PC;
        fpc               = `RESET_PC;
        e1_load_v         = 1'b0;
        e1_load_rd        = '0;
        issued            = 0;
        for (int i = 0; i < `NUM_REGS; i++)
            reg_model[i] = '0;
        // Registers limited to x0..x7 so dependencies come often
        for (int i = 0; i < 64; i++)
        begin
            draw(32, bits);
            draw(3, ra);
            draw(3, rb);
            draw(3, rd);
            draw(2, kind);
            bits[`RS1_LSB +: `REG_IDX_W] = 5'(ra);
            bits[`RS2_LSB +: `REG_IDX_W] = 5'(rb);
            bits[`RD_LSB +: `REG_IDX_W]  = 5'(rd);
            prog_instr[i] = bits;
            prog_kind[i]  = kind[1:0];
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        step_cycle();
        while (issued < NUM_INSTR)
        begin
            @(posedge clk_i);
            step_cycle();
        end
        // One more edge so the last cycle is checked
        @(posedge clk_i);
        @(negedge clk_i);
        $display("Verification passed");
        $finish;
    end

endmodule
